/* hw/s2650_defines.svh */
`ifndef S2650_DEFINES_SVH
`define S2650_DEFINES_SVH

// Datapath sizes
`define S2650_DATA_W 8
`define S2650_ADDR_W 15
`define S2650_NREGS 7

// Opcodes handled outside the ALU group
`define S2650_OP_HALT 8'h40
`define S2650_OP_NOP 8'hC0
`define S2650_OP_LPSL 8'h93
`define S2650_OP_SPSL 8'h13
`define S2650_OP_BCTA 8'h1C
`define S2650_OP_BCFA 8'h9C

// Addressing mode field, opcode bits 3:2
`define S2650_MODE_Z 2'b00
`define S2650_MODE_I 2'b01
`define S2650_MODE_A 2'b11

// PSL bit positions
`define S2650_PSL_CC1 7
`define S2650_PSL_CC0 6
`define S2650_PSL_IDC 5
`define S2650_PSL_RS 4
`define S2650_PSL_WC 3
`define S2650_PSL_OVF 2
`define S2650_PSL_COM 1
`define S2650_PSL_C 0

`define S2650_PSL_RESET 8'h00
`define S2650_PC_RESET 15'h0000

`endif

/* hw/s2650_pkg.sv */
`include "s2650_defines.svh"

package s2650_pkg;

	// Operation field, opcode bits 7:5
	typedef enum logic [2:0] {
		OP_LOD = 3'd0,
		OP_EOR = 3'd1,
		OP_AND = 3'd2,
		OP_IOR = 3'd3,
		OP_ADD = 3'd4,
		OP_SUB = 3'd5,
		OP_STR = 3'd6,
		OP_COM = 3'd7
	} alu_op_t;

	// Same layout as the PSL byte, cc in bits 7:6
	typedef struct packed {
		logic [1:0] cc;
		logic idc;
		logic rs;
		logic wc;
		logic ovf;
		logic com;
		logic c;
	} psl_t;

	typedef enum logic [2:0] {
		IC_ALU,
		IC_BRANCH,
		IC_LPSL,
		IC_SPSL,
		IC_HALT,
		IC_NOP
	} insn_class_t;

	typedef struct packed {
		insn_class_t iclass;
		alu_op_t op;
		logic [1:0] mode;
		logic [1:0] rsel;
		logic branch_false;
		logic [1:0] cond;
		logic [1:0] n_params;
	} dec_t;

	typedef struct packed {
		logic [`S2650_DATA_W-1:0] value;
		logic [1:0] cc;
		logic c;
		logic idc;
		logic ovf;
	} alu_res_t;

	typedef struct packed {
		logic [`S2650_ADDR_W-1:0] addr;
		logic rd;
		logic wr;
		logic [`S2650_DATA_W-1:0] wdata;
	} bus_req_t;

	// Condition code of a result byte
	function automatic logic [1:0] cc_of(input logic [`S2650_DATA_W-1:0] v);
		if (v == '0) begin
			return 2'b00;
		end
		if (v[`S2650_DATA_W-1]) begin
			return 2'b10;
		end
		return 2'b01;
	endfunction

endpackage

/* hw/s2650_decode.sv */
`include "s2650_defines.svh"

module s2650_decode import s2650_pkg::*; (
	input logic [`S2650_DATA_W-1:0] opcode,
	output dec_t dec
);

	always_comb begin
		dec.iclass = IC_NOP;
		dec.op = alu_op_t'(opcode[7:5]);
		dec.mode = opcode[3:2];
		dec.rsel = opcode[1:0];
		dec.branch_false = opcode[7];
		dec.cond = opcode[1:0];
		dec.n_params = 2'd0;

		if (opcode == `S2650_OP_HALT) begin
			dec.iclass = IC_HALT;
		end else if (opcode == `S2650_OP_NOP) begin
			dec.iclass = IC_NOP;
		end else if (opcode == `S2650_OP_LPSL) begin
			dec.iclass = IC_LPSL;
		end else if (opcode == `S2650_OP_SPSL) begin
			dec.iclass = IC_SPSL;
		end else if ({opcode[7:2], 2'b00} == `S2650_OP_BCTA) begin
			dec.iclass = IC_BRANCH;
			dec.n_params = 2'd2;
		end else if ({opcode[7:2], 2'b00} == `S2650_OP_BCFA && opcode[1:0] != 2'd3) begin
			// 9Fh is BXA on the full part
			dec.iclass = IC_BRANCH;
			dec.n_params = 2'd2;
		end else if (!opcode[4]) begin
			case (opcode[3:2])
				`S2650_MODE_Z: begin
					dec.iclass = IC_ALU;
				end
				`S2650_MODE_I: begin
					// No immediate store
					if (opcode[7:5] != OP_STR) begin
						dec.iclass = IC_ALU;
						dec.n_params = 2'd1;
					end
				end
				`S2650_MODE_A: begin
					dec.iclass = IC_ALU;
					dec.n_params = 2'd2;
				end
				default: begin
					// Relative mode falls through as NOP
					dec.iclass = IC_NOP;
				end
			endcase
		end
	end

endmodule

/* hw/s2650_alu.sv */
`include "s2650_defines.svh"

module s2650_alu import s2650_pkg::*; (
	input alu_op_t op,
	input logic [`S2650_DATA_W-1:0] a,
	input logic [`S2650_DATA_W-1:0] b,
	input psl_t psl,
	output alu_res_t res
);

	logic [`S2650_DATA_W-1:0] b_eff;
	logic cin;
	logic [`S2650_DATA_W:0] sum;
	logic [4:0] low_sum;
	logic a_gt_b;

	// Subtract as a + ~b + cin, carry out means no borrow
	always_comb begin
		b_eff = (op == OP_SUB) ? ~b : b;
		if (op == OP_SUB) begin
			cin = psl.wc ? psl.c : 1'b1;
		end else begin
			cin = psl.wc & psl.c;
		end
		sum = {1'b0, a} + {1'b0, b_eff} + {{`S2650_DATA_W{1'b0}}, cin};
		low_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};
	end

	assign a_gt_b = psl.com ? (a > b) : ($signed(a) > $signed(b));

	always_comb begin
		res.value = b;
		res.c = psl.c;
		res.idc = psl.idc;
		res.ovf = psl.ovf;
		case (op)
			OP_LOD: res.value = b;
			OP_EOR: res.value = a ^ b;
			OP_AND: res.value = a & b;
			OP_IOR: res.value = a | b;
			OP_ADD, OP_SUB: begin
				res.value = sum[`S2650_DATA_W-1:0];
				res.c = sum[`S2650_DATA_W];
				res.idc = low_sum[4];
				res.ovf = (a[7] == b_eff[7]) && (sum[7] != a[7]);
			end
			default: res.value = a;
		endcase

		if (op == OP_COM) begin
			res.cc = (a == b) ? 2'b00 : (a_gt_b ? 2'b01 : 2'b10);
		end else begin
			res.cc = cc_of(res.value);
		end
	end

endmodule

/* hw/s2650_regfile.sv */
`include "s2650_defines.svh"

module s2650_regfile (
	input logic clk,
	input logic rst_n,
	input logic rs,
	input logic [1:0] rsel,
	input logic [1:0] wsel,
	input logic we,
	input logic [`S2650_DATA_W-1:0] wdata,
	output logic [`S2650_DATA_W-1:0] reg_q,
	output logic [`S2650_DATA_W-1:0] r0_q
);

	logic [`S2650_DATA_W-1:0] regs [`S2650_NREGS];

	// Slot 0 is r0, slots 1-3 bank 0, slots 4-6 bank 1
	function automatic logic [2:0] slot(input logic bank, input logic [1:0] sel);
		if (sel == 2'd0) begin
			return 3'd0;
		end
		return bank ? ({1'b0, sel} + 3'd3) : {1'b0, sel};
	endfunction

	assign reg_q = regs[slot(rs, rsel)];
	assign r0_q = regs[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `S2650_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[slot(rs, wsel)] <= wdata;
		end
	end

endmodule

/* hw/s2650_sequencer.sv */
`include "s2650_defines.svh"

module s2650_sequencer import s2650_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [`S2650_DATA_W-1:0] rdata,
	output bus_req_t bus,
	output logic halted,
	output logic [`S2650_DATA_W-1:0] opcode,
	input dec_t dec,
	output logic [1:0] rsel,
	output logic rs,
	input logic [`S2650_DATA_W-1:0] reg_q,
	input logic [`S2650_DATA_W-1:0] r0_q,
	output logic we,
	output logic [1:0] wsel,
	output logic [`S2650_DATA_W-1:0] wdata,
	output alu_op_t alu_op,
	output logic [`S2650_DATA_W-1:0] alu_a,
	output logic [`S2650_DATA_W-1:0] alu_b,
	output psl_t psl,
	input alu_res_t alu_res
);

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_PARAM1,
		ST_PARAM2,
		ST_DATA,
		ST_HALT
	} state_t;

	state_t state;
	logic [`S2650_ADDR_W-1:0] pc;
	logic [`S2650_DATA_W-1:0] opcode_q;
	logic [15:0] oper_q;
	psl_t psl_d;
	logic zmode;
	logic is_store;
	logic alu_exec;
	logic taken;
	logic [`S2650_ADDR_W-1:0] data_addr;

	// Opcode comes straight off the bus during fetch
	assign opcode = (state == ST_FETCH) ? rdata : opcode_q;

	assign zmode = (dec.mode == `S2650_MODE_Z);
	assign is_store = (dec.op == OP_STR);
	assign rsel = dec.rsel;
	assign rs = psl.rs;
	assign alu_op = dec.op;
	assign alu_a = zmode ? r0_q : reg_q;
	assign alu_b = zmode ? reg_q : rdata;
	assign halted = (state == ST_HALT);
	assign data_addr = {pc[`S2650_ADDR_W-1 -: 2], oper_q[12:0]};

	always_comb begin
		if (dec.branch_false) begin
			taken = (psl.cc != dec.cond);
		end else begin
			taken = (dec.cond == 2'd3) || (psl.cc == dec.cond);
		end
	end

	// Cycle in which an ALU instruction has its second operand
	always_comb begin
		case (state)
			ST_FETCH: alu_exec = (dec.iclass == IC_ALU) && (dec.n_params == 2'd0);
			ST_PARAM1: alu_exec = (dec.iclass == IC_ALU) && (dec.n_params == 2'd1);
			ST_DATA: alu_exec = 1'b1;
			default: alu_exec = 1'b0;
		endcase
	end

	always_comb begin
		we = 1'b0;
		wsel = dec.rsel;
		wdata = alu_res.value;
		if (alu_exec) begin
			we = (dec.op != OP_COM) && !(is_store && !zmode);
			// Z mode results land in r0, except STRZ
			if (zmode && !is_store) begin
				wsel = 2'd0;
			end
		end
		if (state == ST_FETCH && dec.iclass == IC_SPSL) begin
			we = 1'b1;
			wsel = 2'd0;
			wdata = psl;
		end
	end

	always_comb begin
		bus.addr = pc;
		bus.rd = 1'b0;
		bus.wr = 1'b0;
		bus.wdata = reg_q;
		case (state)
			ST_FETCH, ST_PARAM1, ST_PARAM2: bus.rd = 1'b1;
			ST_DATA: begin
				bus.addr = data_addr;
				bus.rd = !is_store;
				bus.wr = is_store;
			end
			default: bus.rd = 1'b0;
		endcase
		// Bus stays quiet while reset is held
		if (!rst_n) begin
			bus.rd = 1'b0;
			bus.wr = 1'b0;
		end
	end

	always_comb begin
		psl_d = psl;
		if (alu_exec) begin
			psl_d.cc = alu_res.cc;
			psl_d.c = alu_res.c;
			psl_d.idc = alu_res.idc;
			psl_d.ovf = alu_res.ovf;
		end
		if (state == ST_FETCH) begin
			if (dec.iclass == IC_LPSL) begin
				psl_d = psl_t'(r0_q);
			end else if (dec.iclass == IC_SPSL) begin
				psl_d.cc = cc_of(psl);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_FETCH;
			pc <= `S2650_PC_RESET;
			psl <= psl_t'(`S2650_PSL_RESET);
		end else begin
			psl <= psl_d;
			case (state)
				ST_FETCH: begin
					pc <= pc + 1'b1;
					if (dec.iclass == IC_HALT) begin
						state <= ST_HALT;
					end else if (dec.iclass == IC_BRANCH && !taken) begin
						// Skip both address bytes
						pc <= pc + 3'd3;
					end else if (dec.n_params != 2'd0) begin
						state <= ST_PARAM1;
					end
				end
				ST_PARAM1: begin
					pc <= pc + 1'b1;
					state <= (dec.n_params == 2'd2) ? ST_PARAM2 : ST_FETCH;
				end
				ST_PARAM2: begin
					if (dec.iclass == IC_BRANCH) begin
						pc <= {oper_q[14:8], rdata};
						state <= ST_FETCH;
					end else begin
						pc <= pc + 1'b1;
						state <= ST_DATA;
					end
				end
				ST_DATA: state <= ST_FETCH;
				default: state <= ST_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH) begin
			opcode_q <= rdata;
		end
		if (state == ST_PARAM1) begin
			oper_q[15:8] <= rdata;
		end
		if (state == ST_PARAM2) begin
			oper_q[7:0] <= rdata;
		end
	end

endmodule

/* hw/s2650_core.sv */
`include "s2650_defines.svh"

module s2650_core import s2650_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [`S2650_DATA_W-1:0] rdata,
	output bus_req_t bus,
	output logic halted
);

	logic [`S2650_DATA_W-1:0] opcode;
	dec_t dec;
	logic [1:0] rsel;
	logic [1:0] wsel;
	logic rs;
	logic we;
	logic [`S2650_DATA_W-1:0] reg_q;
	logic [`S2650_DATA_W-1:0] r0_q;
	logic [`S2650_DATA_W-1:0] wdata;
	alu_op_t alu_op;
	logic [`S2650_DATA_W-1:0] alu_a;
	logic [`S2650_DATA_W-1:0] alu_b;
	psl_t psl;
	alu_res_t alu_res;

	s2650_sequencer seq0 (
		.clk(clk),
		.rst_n(rst_n),
		.rdata(rdata),
		.bus(bus),
		.halted(halted),
		.opcode(opcode),
		.dec(dec),
		.rsel(rsel),
		.rs(rs),
		.reg_q(reg_q),
		.r0_q(r0_q),
		.we(we),
		.wsel(wsel),
		.wdata(wdata),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.psl(psl),
		.alu_res(alu_res)
	);

	s2650_decode dec0 (
		.opcode(opcode),
		.dec(dec)
	);

	s2650_alu alu0 (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.psl(psl),
		.res(alu_res)
	);

	s2650_regfile rf0 (
		.clk(clk),
		.rst_n(rst_n),
		.rs(rs),
		.rsel(rsel),
		.wsel(wsel),
		.we(we),
		.wdata(wdata),
		.reg_q(reg_q),
		.r0_q(r0_q)
	);

endmodule

/* tb/s2650_mem_model.sv */
`include "s2650_defines.svh"

module s2650_mem_model import s2650_pkg::*; (
	input logic clk,
	input bus_req_t bus,
	output logic [`S2650_DATA_W-1:0] rdata
);

	timeunit 1ns;
	timeprecision 100ps;

	// Whole 15-bit space, filled by the testbench before each run
	logic [`S2650_DATA_W-1:0] mem [1 << `S2650_ADDR_W];

	// Read data valid in the same cycle as the request
	assign rdata = bus.rd ? mem[bus.addr] : '0;

	always @(posedge clk) begin
		if (bus.wr) begin
			mem[bus.addr] = bus.wdata;
		end
	end

endmodule

/* tb/s2650_tb.sv */
`include "s2650_defines.svh"

module s2650_tb import s2650_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [1:0] K_ALU = 2'd0;
	localparam logic [1:0] K_BANK = 2'd1;
	localparam logic [1:0] K_ABS = 2'd2;
	localparam logic [1:0] K_CMP = 2'd3;
	localparam int CYCLES_PER_ENTRY = 80;

	// cond bit 2 selects BCFA
	typedef struct packed {
		logic [1:0] kind;
		logic [2:0] op;
		logic [7:0] pslv;
		logic [2:0] cond;
		logic [7:0] x;
		logic [7:0] y;
	} entry_t;

	logic clk;
	logic rst_n;
	logic [7:0] rdata;
	bus_req_t bus;
	logic halted;
	entry_t tbl [$];
	logic tbl_ready;
	integer seed;
	int errors;
	logic [14:0] pc_b;
	logic [7:0] mr0;
	logic [7:0] mr1 [2];
	logic [7:0] mpsl;
	logic [14:0] exp_addr [$];
	logic [7:0] exp_data [$];
	logic [14:0] obs_addr [$];
	logic [7:0] obs_data [$];
	logic rst_prev = 1'b1;

	s2650_core dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.rdata(rdata),
		.bus(bus),
		.halted(halted)
	);

	s2650_mem_model mem0 (
		.clk(clk),
		.bus(bus),
		.rdata(rdata)
	);

	always #10 clk = ~clk;

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [1:0] cc_ref(input logic [7:0] v);
		if (v == 8'h00) begin
			return 2'b00;
		end
		return v[7] ? 2'b10 : 2'b01;
	endfunction

	task automatic alu_ref(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
			output logic [7:0] v);
		logic cin;
		logic bor;
		logic [8:0] wide;
		cin = mpsl[`S2650_PSL_WC] & mpsl[`S2650_PSL_C];
		bor = mpsl[`S2650_PSL_WC] ? ~mpsl[`S2650_PSL_C] : 1'b0;
		v = b;
		case (op)
			OP_EOR: v = a ^ b;
			OP_AND: v = a & b;
			OP_IOR: v = a | b;
			OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b} + {8'd0, cin};
				v = wide[7:0];
				mpsl[`S2650_PSL_C] = wide[8];
				mpsl[`S2650_PSL_IDC] = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin}) > 5'h0f;
				mpsl[`S2650_PSL_OVF] = (a[7] == b[7]) && (v[7] != a[7]);
			end
			OP_SUB: begin
				v = a - b - {7'd0, bor};
				mpsl[`S2650_PSL_C] = {1'b0, a} >= ({1'b0, b} + {8'd0, bor});
				mpsl[`S2650_PSL_IDC] = {1'b0, a[3:0]} >= ({1'b0, b[3:0]} + {4'd0, bor});
				mpsl[`S2650_PSL_OVF] = (a[7] != b[7]) && (v[7] != a[7]);
			end
			default: v = b;
		endcase
		mpsl[7:6] = cc_ref(v);
	endtask

	task automatic emit(input logic [7:0] b);
		mem0.mem[pc_b] = b;
		pc_b = pc_b + 15'd1;
	endtask

	task automatic lodi(input logic [1:0] r, input logic [7:0] v);
		emit({6'b000001, r});
		emit(v);
		if (r == 2'd0) begin
			mr0 = v;
		end else begin
			mr1[mpsl[`S2650_PSL_RS]] = v;
		end
		mpsl[7:6] = cc_ref(v);
	endtask

	task automatic lpsl();
		emit(`S2650_OP_LPSL);
		mpsl = mr0;
	endtask

	task automatic spsl();
		emit(`S2650_OP_SPSL);
		mr0 = mpsl;
		mpsl[7:6] = cc_ref(mr0);
	endtask

	// Only a live store is expected on the bus
	task automatic stra(input logic [1:0] r, input logic [15:0] a, input logic live);
		logic [7:0] v;
		emit({6'b110011, r});
		emit(a[15:8]);
		emit(a[7:0]);
		v = (r == 2'd0) ? mr0 : mr1[mpsl[`S2650_PSL_RS]];
		if (live) begin
			exp_addr.push_back(a[14:0]);
			exp_data.push_back(v);
			mpsl[7:6] = cc_ref(v);
		end
	endtask

	task automatic alu_imm(input logic [2:0] op, input logic [7:0] v);
		logic [7:0] res;
		emit({op, 5'b00101});
		emit(v);
		alu_ref(op, mr1[mpsl[`S2650_PSL_RS]], v, res);
		mr1[mpsl[`S2650_PSL_RS]] = res;
	endtask

	task automatic alu_zero(input logic [2:0] op);
		logic [7:0] res;
		emit({op, 5'b00001});
		alu_ref(op, mr0, mr1[mpsl[`S2650_PSL_RS]], res);
		mr0 = res;
	endtask

	task automatic build(input entry_t e);
		logic gt;
		logic [1:0] cc;
		logic taken;
		for (int i = 0; i < (1 << `S2650_ADDR_W); i++) begin
			mem0.mem[i] = 8'(i ^ (i >> 7));
		end
		exp_addr.delete();
		exp_data.delete();
		obs_addr.delete();
		obs_data.delete();
		pc_b = '0;
		mr0 = '0;
		mr1[0] = '0;
		mr1[1] = '0;
		mpsl = `S2650_PSL_RESET;
		case (e.kind)
			K_ALU: begin
				lodi(2'd0, e.pslv);
				lpsl();
				lodi(2'd1, e.x);
				alu_imm(e.op, e.y);
				stra(2'd1, 16'h0100, 1'b1);
				spsl();
				stra(2'd0, 16'h0101, 1'b1);
				alu_zero(e.op);
				stra(2'd0, 16'h0102, 1'b1);
				spsl();
				stra(2'd0, 16'h0103, 1'b1);
			end
			K_BANK: begin
				lodi(2'd0, 8'h10);
				lpsl();
				lodi(2'd1, e.x);
				stra(2'd0, 16'h0100, 1'b1);
				lodi(2'd0, 8'h00);
				lpsl();
				lodi(2'd1, e.y);
				stra(2'd1, 16'h0101, 1'b1);
				lodi(2'd0, 8'h10);
				lpsl();
				stra(2'd1, 16'h0102, 1'b1);
				stra(2'd0, 16'h0103, 1'b1);
			end
			K_ABS: begin
				// Operand 72yyh lands on 12yyh in page 0
				mem0.mem[{7'h12, e.y}] = e.x;
				emit(8'h0D);
				emit(8'h72);
				emit(e.y);
				mr1[0] = e.x;
				mpsl[7:6] = cc_ref(e.x);
				stra(2'd1, 16'h0100, 1'b1);
			end
			default: begin
				lodi(2'd0, e.pslv);
				lpsl();
				lodi(2'd1, e.x);
				emit(8'hE5);
				emit(e.y);
				gt = mpsl[`S2650_PSL_COM] ? (e.x > e.y) : ($signed(e.x) > $signed(e.y));
				cc = (e.x == e.y) ? 2'b00 : (gt ? 2'b01 : 2'b10);
				mpsl[7:6] = cc;
				if (e.cond[2]) begin
					taken = (cc != e.cond[1:0]);
					emit(`S2650_OP_BCFA | {6'd0, e.cond[1:0]});
				end else begin
					taken = (e.cond[1:0] == 2'd3) || (cc == e.cond[1:0]);
					emit(`S2650_OP_BCTA | {6'd0, e.cond[1:0]});
				end
				emit(8'h00);
				emit(8'h40);
				stra(2'd1, 16'h0101, !taken);
				emit(`S2650_OP_HALT);
				pc_b = 15'h0040;
				stra(2'd1, 16'h0102, taken);
			end
		endcase
		emit(`S2650_OP_HALT);
	endtask

	task automatic add(input logic [1:0] kind, input logic [2:0] op, input logic [7:0] pslv,
			input logic [2:0] cond);
		entry_t e;
		e.kind = kind;
		e.op = op;
		e.pslv = pslv;
		e.cond = cond;
		e.x = 8'($random(seed));
		e.y = 8'($random(seed));
		tbl.push_back(e);
	endtask

	task automatic run_entry(input entry_t e);
		@(negedge clk);
		rst_n = 1'b0;
		build(e);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		while (!halted) begin
			@(negedge clk);
		end
		// Bus must stay idle after halt
		repeat (10) @(negedge clk);
		check("write count", obs_addr.size(), exp_addr.size());
		for (int i = 0; i < exp_addr.size() && i < obs_addr.size(); i++) begin
			check("write address", obs_addr[i], exp_addr[i]);
			check("write data", obs_data[i], exp_data[i]);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			if (!rst_prev) begin
				check("rd during reset", bus.rd, 0);
				check("wr during reset", bus.wr, 0);
				check("halted during reset", halted, 0);
			end
		end else begin
			// First cycle after release fetches from 0
			if (!rst_prev) begin
				check("rd in first cycle after reset", bus.rd, 1);
				check("first read address", bus.addr, 0);
				check("halted at first fetch", halted, 0);
			end
			if (bus.wr) begin
				obs_addr.push_back(bus.addr);
				obs_data.push_back(bus.wdata);
				check("halted at write", halted, 0);
			end
			if (halted) begin
				check("rd while halted", bus.rd, 0);
				check("wr while halted", bus.wr, 0);
			end
		end
		rst_prev <= rst_n;
	end

	initial begin
		wait (tbl_ready);
		#(tbl.size() * CYCLES_PER_ENTRY * 20);
		$display("Timeout: the run did not finish within its time limit");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		errors = 0;
		seed = 43;
		tbl_ready = 1'b0;
		for (int op = 0; op < 6; op++) begin
			add(K_ALU, 3'(op), 8'h00, 3'd0);
			add(K_ALU, 3'(op), 8'h09, 3'd0);
		end
		// Carry clear with WC, and carry set without WC
		add(K_ALU, OP_ADD, 8'h08, 3'd0);
		add(K_ALU, OP_SUB, 8'h08, 3'd0);
		add(K_ALU, OP_ADD, 8'h01, 3'd0);
		add(K_ALU, OP_SUB, 8'h01, 3'd0);
		add(K_BANK, OP_LOD, 8'h00, 3'd0);
		add(K_ABS, OP_LOD, 8'h00, 3'd0);
		add(K_ABS, OP_LOD, 8'h00, 3'd0);
		add(K_CMP, OP_COM, 8'h00, 3'd1);
		add(K_CMP, OP_COM, 8'h02, 3'd2);
		add(K_CMP, OP_COM, 8'h00, 3'd3);
		add(K_CMP, OP_COM, 8'h02, 3'd4);
		add(K_CMP, OP_COM, 8'h00, 3'd5);
		add(K_CMP, OP_COM, 8'h02, 3'd6);
		tbl_ready = 1'b1;
		foreach (tbl[i]) begin
			run_entry(tbl[i]);
		end
		$display("Entries run: %0d, errors: %0d", tbl.size(), errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* s2650_core.f */
+incdir+hw
hw/s2650_pkg.sv
hw/s2650_decode.sv
hw/s2650_alu.sv
hw/s2650_regfile.sv
hw/s2650_sequencer.sv
hw/s2650_core.sv
tb/s2650_mem_model.sv
tb/s2650_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the s2650_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	-f s2650_core.f --top-module s2650_tb -o s2650_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/s2650_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
